// ==== include/rv32_consts.svh ====
`ifndef RV32_CONSTS_SVH
`define RV32_CONSTS_SVH

// Width of registers, ALU and memory words
`define RV32_XLEN 32

// Instruction memory depth in words
`define RV32_IMEM_WORDS 256

// Data memory depth in words
`define RV32_DMEM_WORDS 256

// Byte address of the first fetch after reset or a load
`define RV32_RESET_PC 32'h0000_0000

// No forwarding and no interlock in the pipeline
// A reader must sit this many instructions behind the writer of its source
`define RV32_HAZARD_GAP 4

`endif

// ==== hw/rv32_isa_pkg.sv ====
package rv32_isa_pkg;

    // Register index
    typedef logic [4:0] rv32_reg_idx_t;

    // Major opcodes the core executes, everything else is a NOP
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } rv32_opcode_e;

    // funct3 codes of the integer group
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    // Whole-word width code for loads and stores
    localparam logic [2:0] F3_LW_SW   = 3'b010;

    // funct7 codes, ALT selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } rv32_alu_op_e;

    // ============================================================
    // Instruction format views
    // ============================================================
    // Opcode kept as raw bits so unknown encodings stay legal values
    typedef struct packed {
        logic [6:0]    funct7;
        rv32_reg_idx_t rs2;
        rv32_reg_idx_t rs1;
        logic [2:0]    funct3;
        rv32_reg_idx_t rd;
        logic [6:0]    opcode;
    } rv32_r_fmt_t;

    typedef struct packed {
        logic [11:0]   imm;
        rv32_reg_idx_t rs1;
        logic [2:0]    funct3;
        rv32_reg_idx_t rd;
        logic [6:0]    opcode;
    } rv32_i_fmt_t;

    typedef struct packed {
        logic [6:0]    imm_hi;
        rv32_reg_idx_t rs2;
        rv32_reg_idx_t rs1;
        logic [2:0]    funct3;
        logic [4:0]    imm_lo;
        logic [6:0]    opcode;
    } rv32_s_fmt_t;

    typedef struct packed {
        logic [19:0]   imm;
        rv32_reg_idx_t rd;
        logic [6:0]    opcode;
    } rv32_u_fmt_t;

    // Same 32 bits, read through whichever view the opcode calls for
    typedef union packed {
        rv32_r_fmt_t r;
        rv32_i_fmt_t i;
        rv32_s_fmt_t s;
        rv32_u_fmt_t u;
    } rv32_instr_u;

endpackage

// ==== hw/rv32_mem_pkg.sv ====
`include "rv32_consts.svh"

package rv32_mem_pkg;

    // Data word, also the register width
    typedef logic [`RV32_XLEN-1:0] rv32_word_t;

    // Byte address of an instruction
    typedef logic [`RV32_XLEN-1:0] rv32_pc_t;

    // Word addresses into the two memories
    typedef logic [$clog2(`RV32_IMEM_WORDS)-1:0] rv32_iaddr_t;
    typedef logic [$clog2(`RV32_DMEM_WORDS)-1:0] rv32_daddr_t;

endpackage

// ==== hw/rv32_word_ram.sv ====
module rv32_word_ram #(
    parameter int  DEPTH = 256,
    parameter int  WIDTH = 32,
    localparam int AW    = $clog2(DEPTH)
) (
    input  logic             clk,
    input  logic             we,
    input  logic [AW-1:0]    waddr,
    input  logic [WIDTH-1:0] wdata,
    input  logic [AW-1:0]    raddr,
    output logic [WIDTH-1:0] rdata
);

    // Word array, one write port and one read port
    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // Registered read, old data on a same-address write
        rdata <= mem[raddr];
    end

endmodule

// ==== hw/rv32_regfile.sv ====
module rv32_regfile (
    input  logic                        clk,
    input  rv32_isa_pkg::rv32_reg_idx_t ra1,
    output rv32_mem_pkg::rv32_word_t    rd1,
    input  rv32_isa_pkg::rv32_reg_idx_t ra2,
    output rv32_mem_pkg::rv32_word_t    rd2,
    input  logic                        we,
    input  rv32_isa_pkg::rv32_reg_idx_t wa,
    input  rv32_mem_pkg::rv32_word_t    wd
);

    import rv32_mem_pkg::*;

    // x1..x31, x0 has no storage
    rv32_word_t regs [1:31];

    // Writes to x0 are dropped
    always_ff @(posedge clk) begin
        if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // Combinational reads
    // No bypass, so a read in the write cycle sees the old value
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// ==== hw/rv32_decoder.sv ====
module rv32_decoder (
    input  rv32_isa_pkg::rv32_instr_u   instr,
    output rv32_isa_pkg::rv32_reg_idx_t rs1,
    output rv32_isa_pkg::rv32_reg_idx_t rs2,
    output rv32_isa_pkg::rv32_reg_idx_t rd,
    output rv32_mem_pkg::rv32_word_t    imm,
    output rv32_isa_pkg::rv32_alu_op_e  alu_op,
    output logic                        use_imm,
    output logic                        writes_rd,
    output logic                        is_load,
    output logic                        is_store,
    output logic                        is_lui
);

    import rv32_isa_pkg::*;

    logic [2:0] f3;
    logic [6:0] f7;
    logic       alt;
    logic       legal;
    logic       is_shift;

    // Integer operation from funct3, alt picks SUB or SRA
    function automatic rv32_alu_op_e alu_from_f3(input logic [2:0] funct3,
                                                 input logic       use_alt);
        case (funct3)
            F3_ADD_SUB: alu_from_f3 = use_alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_from_f3 = ALU_SLL;
            F3_SLT:     alu_from_f3 = ALU_SLT;
            F3_SLTU:    alu_from_f3 = ALU_SLTU;
            F3_XOR:     alu_from_f3 = ALU_XOR;
            F3_SRL_SRA: alu_from_f3 = use_alt ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_from_f3 = ALU_OR;
            F3_AND:     alu_from_f3 = ALU_AND;
            default:    alu_from_f3 = ALU_ADD;
        endcase
    endfunction

    // Register fields share their bit positions in all formats
    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;
    assign rd  = instr.r.rd;
    assign f3  = instr.r.funct3;
    assign f7  = instr.r.funct7;

    assign is_shift = (f3 == F3_SLL) || (f3 == F3_SRL_SRA);

    always_comb begin
        // Defaults give a NOP
        alt       = 1'b0;
        legal     = 1'b0;
        imm       = '0;
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        writes_rd = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_lui    = 1'b0;
        case (instr.r.opcode)
            OP: begin
                // Only ADD and SRL have an alternate form
                alt       = (f7 == F7_ALT);
                legal     = (f7 == F7_BASE) ||
                            (alt && ((f3 == F3_ADD_SUB) || (f3 == F3_SRL_SRA)));
                alu_op    = alu_from_f3(f3, alt);
                writes_rd = legal;
            end
            OP_IMM: begin
                // ADDI has no SUB form, its top bits are immediate
                alt       = (f3 == F3_SRL_SRA) && (f7 == F7_ALT);
                legal     = !is_shift || (f7 == F7_BASE) || alt;
                // Shift amount sits where rs2 would be
                imm       = is_shift ? {27'b0, instr.r.rs2}
                                     : {{20{instr.i.imm[11]}}, instr.i.imm};
                alu_op    = alu_from_f3(f3, alt);
                use_imm   = legal;
                writes_rd = legal;
            end
            LUI: begin
                imm       = {instr.u.imm, 12'b0};
                writes_rd = 1'b1;
                is_lui    = 1'b1;
            end
            LOAD: begin
                // Word loads only, address is rs1 plus I immediate
                legal     = (f3 == F3_LW_SW);
                imm       = {{20{instr.i.imm[11]}}, instr.i.imm};
                use_imm   = legal;
                writes_rd = legal;
                is_load   = legal;
            end
            STORE: begin
                // S immediate split around rs2
                legal     = (f3 == F3_LW_SW);
                imm       = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
                use_imm   = legal;
                is_store  = legal;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== hw/rv32_alu.sv ====
`include "rv32_consts.svh"

module rv32_alu (
    input  rv32_mem_pkg::rv32_word_t   a,
    input  rv32_mem_pkg::rv32_word_t   b,
    input  rv32_isa_pkg::rv32_alu_op_e op,
    output rv32_mem_pkg::rv32_word_t   res
);

    import rv32_isa_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    // Shifts use the low five bits of b only
    assign shamt = b[4:0];

    // Both compares formed once, one of them picked below
    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a - b;
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_SLL:  res = a << shamt;
            ALU_SRL:  res = a >> shamt;
            // Sign bit fills from the left
            ALU_SRA:  res = $signed(a) >>> shamt;
            ALU_SLT:  res = {{(`RV32_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: res = {{(`RV32_XLEN-1){1'b0}}, lt_u};
            default:  res = '0;
        endcase
    end

endmodule

// ==== hw/rv32_core.sv ====
`include "rv32_consts.svh"

module rv32_core (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      program_mode,
    input  logic                      imem_we,
    input  rv32_mem_pkg::rv32_iaddr_t imem_addr,
    input  rv32_mem_pkg::rv32_word_t  imem_wdata,
    input  logic                      dmem_we,
    input  rv32_mem_pkg::rv32_daddr_t dmem_addr,
    input  rv32_mem_pkg::rv32_word_t  dmem_wdata,
    output rv32_mem_pkg::rv32_word_t  dmem_rdata
);

    import rv32_isa_pkg::*;
    import rv32_mem_pkg::*;

    // ==========================================================
    // Stage signals
    // ==========================================================
    // Fetch
    rv32_pc_t      pc;
    rv32_iaddr_t   fetch_addr;

    // Decode, instruction arrives from the instruction RAM
    logic          dec_live;
    rv32_instr_u   dec_instr;
    rv32_reg_idx_t dec_rs1;
    rv32_reg_idx_t dec_rs2;
    rv32_reg_idx_t dec_rd;
    rv32_word_t    dec_imm;
    rv32_alu_op_e  dec_alu_op;
    logic          dec_use_imm;
    logic          dec_writes_rd;
    logic          dec_is_load;
    logic          dec_is_store;
    logic          dec_is_lui;
    rv32_word_t    rf_rd1;
    rv32_word_t    rf_rd2;

    // Execute
    logic          ex_live;
    rv32_word_t    ex_rs1_val;
    rv32_word_t    ex_rs2_val;
    rv32_word_t    ex_imm;
    rv32_alu_op_e  ex_alu_op;
    logic          ex_use_imm;
    logic          ex_writes_rd;
    logic          ex_is_load;
    logic          ex_is_store;
    logic          ex_is_lui;
    rv32_reg_idx_t ex_rd;
    rv32_word_t    alu_b;
    rv32_word_t    alu_res;

    // Memory
    logic          mem_live;
    rv32_word_t    mem_res;
    rv32_word_t    mem_rs2;
    rv32_word_t    mem_imm;
    rv32_reg_idx_t mem_rd;
    logic          mem_writes_rd;
    logic          mem_is_load;
    logic          mem_is_store;
    logic          mem_is_lui;
    rv32_daddr_t   mem_daddr;
    logic          core_dmem_we;

    // Data memory port after the host mux
    logic          dm_we;
    rv32_daddr_t   dm_addr;
    rv32_word_t    dm_wdata;
    rv32_word_t    dm_rdata;

    // Writeback
    logic          wb_live;
    rv32_word_t    wb_res;
    rv32_word_t    wb_imm;
    rv32_reg_idx_t wb_rd;
    logic          wb_writes_rd;
    logic          wb_is_load;
    logic          wb_is_lui;
    logic          rf_we;
    rv32_word_t    rf_wd;

    // ==========================================================
    // Fetch and live bits
    // ==========================================================
    // Program mode holds the PC at reset value and flushes all stages
    always_ff @(posedge clk) begin
        if (rst || program_mode) begin
            pc       <= `RV32_RESET_PC;
            dec_live <= 1'b0;
            ex_live  <= 1'b0;
            mem_live <= 1'b0;
            wb_live  <= 1'b0;
        end else begin
            // No branches, so the PC only steps forward
            pc       <= pc + 32'd4;
            dec_live <= 1'b1;
            ex_live  <= dec_live;
            mem_live <= ex_live;
            wb_live  <= mem_live;
        end
    end

    // Word address of the PC
    assign fetch_addr = pc[$bits(rv32_iaddr_t)+1:2];

    // Host writes at any time, core only reads
    rv32_word_ram #(
        .DEPTH (`RV32_IMEM_WORDS),
        .WIDTH (`RV32_XLEN)
    ) i_mem (
        .clk   (clk),
        .we    (imem_we),
        .waddr (imem_addr),
        .wdata (imem_wdata),
        .raddr (fetch_addr),
        .rdata (dec_instr)
    );

    // ==========================================================
    // Decode
    // ==========================================================
    rv32_decoder i_decoder (
        .instr     (dec_instr),
        .rs1       (dec_rs1),
        .rs2       (dec_rs2),
        .rd        (dec_rd),
        .imm       (dec_imm),
        .alu_op    (dec_alu_op),
        .use_imm   (dec_use_imm),
        .writes_rd (dec_writes_rd),
        .is_load   (dec_is_load),
        .is_store  (dec_is_store),
        .is_lui    (dec_is_lui)
    );

    // Read ports in decode, write port from writeback
    rv32_regfile i_regfile (
        .clk (clk),
        .ra1 (dec_rs1),
        .rd1 (rf_rd1),
        .ra2 (dec_rs2),
        .rd2 (rf_rd2),
        .we  (rf_we),
        .wa  (wb_rd),
        .wd  (rf_wd)
    );

    // ==========================================================
    // Execute
    // ==========================================================
    always_ff @(posedge clk) begin
        ex_rs1_val   <= rf_rd1;
        ex_rs2_val   <= rf_rd2;
        ex_imm       <= dec_imm;
        ex_alu_op    <= dec_alu_op;
        ex_use_imm   <= dec_use_imm;
        ex_writes_rd <= dec_writes_rd;
        ex_is_load   <= dec_is_load;
        ex_is_store  <= dec_is_store;
        ex_is_lui    <= dec_is_lui;
        ex_rd        <= dec_rd;
    end

    // Immediate forms and memory address use the immediate
    assign alu_b = ex_use_imm ? ex_imm : ex_rs2_val;

    rv32_alu i_alu (
        .a   (ex_rs1_val),
        .b   (alu_b),
        .op  (ex_alu_op),
        .res (alu_res)
    );

    // ==========================================================
    // Memory
    // ==========================================================
    always_ff @(posedge clk) begin
        mem_res       <= alu_res;
        mem_rs2       <= ex_rs2_val;
        mem_imm       <= ex_imm;
        mem_rd        <= ex_rd;
        mem_writes_rd <= ex_writes_rd;
        mem_is_load   <= ex_is_load;
        mem_is_store  <= ex_is_store;
        mem_is_lui    <= ex_is_lui;
    end

    // Byte address to word address, no offset
    assign mem_daddr    = mem_res[$bits(rv32_daddr_t)+1:2];
    assign core_dmem_we = mem_live && mem_is_store && !program_mode;

    // Host owns the data memory while program mode is high
    assign dm_we    = program_mode ? dmem_we    : core_dmem_we;
    assign dm_addr  = program_mode ? dmem_addr  : mem_daddr;
    assign dm_wdata = program_mode ? dmem_wdata : mem_rs2;

    rv32_word_ram #(
        .DEPTH (`RV32_DMEM_WORDS),
        .WIDTH (`RV32_XLEN)
    ) d_mem (
        .clk   (clk),
        .we    (dm_we),
        .waddr (dm_addr),
        .wdata (dm_wdata),
        .raddr (dm_addr),
        .rdata (dm_rdata)
    );

    // Host read data, one cycle after dmem_addr
    assign dmem_rdata = dm_rdata;

    // ==========================================================
    // Writeback
    // ==========================================================
    always_ff @(posedge clk) begin
        wb_res       <= mem_res;
        wb_imm       <= mem_imm;
        wb_rd        <= mem_rd;
        wb_writes_rd <= mem_writes_rd;
        wb_is_load   <= mem_is_load;
        wb_is_lui    <= mem_is_lui;
    end

    // LUI writes its immediate, LW the RAM output
    assign rf_wd = wb_is_lui  ? wb_imm   :
                   wb_is_load ? dm_rdata : wb_res;

    // Bubbles and NOPs never write
    assign rf_we = wb_live && wb_writes_rd && !program_mode;

endmodule

// ==== tests/rv32_core_chk.sv ====
`include "rv32_consts.svh"

module rv32_core_chk (
    input logic                   clk,
    input logic                   rst,
    input logic                   program_mode,
    input rv32_mem_pkg::rv32_pc_t pc,
    input logic                   core_dmem_we
);

    timeunit 1ns;
    timeprecision 100ps;

    import rv32_mem_pkg::*;

    localparam rv32_pc_t RESET_PC = `RV32_RESET_PC;

    // Count of failed assertions
    int fails = 0;

    // Host owns the data memory in program mode, nothing moves in reset
    a_no_core_write: assert property (@(posedge clk) (rst || program_mode) |-> !core_dmem_we)
        else begin
            fails++;
            $error("core wrote data memory during reset or program mode");
        end

    // Fetch restarts from the reset address after a load
    a_pc_reset: assert property (@(posedge clk) (rst || program_mode) |=> (pc == RESET_PC))
        else begin
            fails++;
            $error("PC not at reset address after reset or program mode");
        end

    // No branches, so a running core only steps forward one word
    a_pc_step: assert property (@(posedge clk)
        (!rst && !program_mode) |=> (pc == $past(pc) + 32'd4))
        else begin
            fails++;
            $error("PC did not advance by 4 while running");
        end

endmodule

bind rv32_core rv32_core_chk i_chk (
    .clk          (clk),
    .rst          (rst),
    .program_mode (program_mode),
    .pc           (pc),
    .core_dmem_we (core_dmem_we)
);

// ==== tests/rv32_core_tb.sv ====
`include "rv32_consts.svh"

module rv32_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rv32_isa_pkg::*;
    import rv32_mem_pkg::*;

    // ============================================================
    // Run limits
    // ============================================================
    // Per test at most imem load plus run, dmem load plus two-cycle reads
    localparam int TEST_BOUND     = 2 * `RV32_IMEM_WORDS + 3 * `RV32_DMEM_WORDS + 64;
    localparam int NUM_TESTS      = 5;
    localparam int TIMEOUT_CYCLES = 8 + NUM_TESTS * TEST_BOUND + 100;
    // addi x0, x0, 0
    localparam rv32_word_t NOP_WORD = 32'h0000_0013;

    logic        clk;
    logic        rst;
    logic        program_mode;
    logic        imem_we;
    rv32_iaddr_t imem_addr;
    rv32_word_t  imem_wdata;
    logic        dmem_we;
    rv32_daddr_t dmem_addr;
    rv32_word_t  dmem_wdata;
    rv32_word_t  dmem_rdata;

    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;
    string test_name;

    // Program image, dmem preload and expected dmem words of one test
    rv32_word_t  prog [$];
    rv32_daddr_t init_addr [$];
    rv32_word_t  init_data [$];
    rv32_daddr_t chk_addr [$];
    rv32_word_t  chk_data [$];

    rv32_core i_dut (
        .clk          (clk),
        .rst          (rst),
        .program_mode (program_mode),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .dmem_we      (dmem_we),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_rdata   (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ============================================================
    // Instruction encoders and reference model
    // ============================================================
    function automatic rv32_word_t enc_r(input logic [6:0] f7, input rv32_reg_idx_t rs2,
                                         input rv32_reg_idx_t rs1, input logic [2:0] f3,
                                         input rv32_reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic rv32_word_t enc_i(input logic [11:0] imm, input rv32_reg_idx_t rs1,
                                         input logic [2:0] f3, input rv32_reg_idx_t rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // S format splits the offset around rs2
    function automatic rv32_word_t enc_s(input logic [11:0] imm, input rv32_reg_idx_t rs2,
                                         input rv32_reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
    endfunction

    function automatic rv32_word_t enc_u(input logic [19:0] imm, input rv32_reg_idx_t rd);
        return {imm, rd, LUI};
    endfunction

    function automatic rv32_word_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // RV32I integer result, alt selects SUB and SRA
    function automatic rv32_word_t model_op(input logic [2:0] f3, input logic alt,
                                            input rv32_word_t a, input rv32_word_t b);
        model_op = '0;
        case (f3)
            F3_ADD_SUB: begin
                if (alt) model_op = a - b;
                else model_op = a + b;
            end
            F3_SLL:  model_op = a << b[4:0];
            F3_SLT:  model_op = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU: model_op = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  model_op = a ^ b;
            F3_SRL_SRA: begin
                // Kept apart so the arithmetic shift stays signed
                if (alt) model_op = $signed(a) >>> b[4:0];
                else model_op = a >> b[4:0];
            end
            F3_OR:   model_op = a | b;
            F3_AND:  model_op = a & b;
            default: model_op = '0;
        endcase
    endfunction

    // ============================================================
    // Program building and host access
    // ============================================================
    // Every instruction is followed by enough NOPs to clear the hazard
    task automatic emit(input rv32_word_t w);
        prog.push_back(w);
        repeat (`RV32_HAZARD_GAP - 1) prog.push_back(NOP_WORD);
    endtask

    task automatic preload(input rv32_daddr_t addr, input rv32_word_t val);
        init_addr.push_back(addr);
        init_data.push_back(val);
    endtask

    task automatic expect_word(input rv32_daddr_t addr, input rv32_word_t val);
        chk_addr.push_back(addr);
        chk_data.push_back(val);
    endtask

    // LW rd, addr*4(x0)
    task automatic load_reg(input rv32_reg_idx_t rd, input rv32_daddr_t addr);
        emit(enc_i({2'b00, addr, 2'b00}, 5'd0, F3_LW_SW, rd, LOAD));
    endtask

    // SW rs, addr*4(x0) and the word it should leave behind
    task automatic store_reg(input rv32_reg_idx_t rs, input rv32_daddr_t addr,
                             input rv32_word_t exp);
        emit(enc_s({2'b00, addr, 2'b00}, rs, 5'd0, F3_LW_SW));
        expect_word(addr, exp);
    endtask

    // Zero tail keeps fetch past the program on NOPs
    task automatic load_imem();
        for (int i = 0; i < prog.size() + 16; i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= 8'(i);
            imem_wdata <= (i < prog.size()) ? prog[i] : '0;
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    task automatic load_dmem();
        for (int i = 0; i < init_addr.size(); i++) begin
            @(posedge clk);
            dmem_we    <= 1'b1;
            dmem_addr  <= init_addr[i];
            dmem_wdata <= init_data[i];
        end
        @(posedge clk);
        dmem_we <= 1'b0;
        init_addr.delete();
        init_data.delete();
    endtask

    // Read data settles one cycle after the address, sampled mid-cycle
    task automatic host_read(input rv32_daddr_t addr, output rv32_word_t data);
        @(posedge clk);
        dmem_we   <= 1'b0;
        dmem_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        data = dmem_rdata;
    endtask

    task automatic check_word(input rv32_daddr_t addr, input rv32_word_t got,
                              input rv32_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0t %s: dmem_rdata word %0d got %08h expected %08h",
                     $time, test_name, addr, got, exp);
        end
    endtask

    task automatic read_and_check();
        rv32_word_t got;
        for (int i = 0; i < chk_addr.size(); i++) begin
            host_read(chk_addr[i], got);
            check_word(chk_addr[i], got, chk_data[i]);
        end
        chk_addr.delete();
        chk_data.delete();
    endtask

    // Load, run with slack for the pipeline to drain, then read back
    task automatic run_program();
        int len;
        len = prog.size();
        load_imem();
        load_dmem();
        @(posedge clk);
        program_mode <= 1'b0;
        repeat (len + 10) @(posedge clk);
        program_mode <= 1'b1;
        prog.delete();
        read_and_check();
    endtask

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic host_rw_test();
        rv32_word_t w;
        test_name = "host_rw";
        for (int a = 0; a < `RV32_DMEM_WORDS; a++) begin
            w = $urandom;
            preload(8'(a), w);
            expect_word(8'(a), w);
        end
        load_dmem();
        read_and_check();
    endtask

    task automatic imm_alu_test();
        rv32_word_t  src [2];
        logic [2:0]  f3s [6];
        logic [11:0] imm;
        logic [19:0] uimm;
        rv32_daddr_t out;
        test_name = "imm_alu";
        f3s    = '{F3_ADD_SUB, F3_SLT, F3_SLTU, F3_XOR, F3_OR, F3_AND};
        src[0] = $urandom;
        src[1] = $urandom;
        preload(8'd0, src[0]);
        preload(8'd1, src[1]);
        load_reg(5'd1, 8'd0);
        load_reg(5'd2, 8'd1);
        out = 8'd32;
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < 6; k++) begin
                imm = 12'($urandom);
                emit(enc_i(imm, 5'(s + 1), f3s[k], 5'd3, OP_IMM));
                store_reg(5'd3, out, model_op(f3s[k], 1'b0, src[s], sext12(imm)));
                out++;
            end
        end
        // LUI fills the upper 20 bits, low bits zero
        uimm = 20'($urandom);
        emit(enc_u(uimm, 5'd3));
        store_reg(5'd3, out, {uimm, 12'h000});
        run_program();
    endtask

    task automatic reg_alu_test();
        rv32_word_t  v [4];
        logic [2:0]  f3s [10];
        logic        alts [10];
        int          sel [3];
        int          ra;
        int          rb;
        rv32_daddr_t out;
        test_name = "reg_alu";
        f3s  = '{F3_ADD_SUB, F3_ADD_SUB, F3_SLL, F3_SLT, F3_SLTU,
                 F3_XOR, F3_SRL_SRA, F3_SRL_SRA, F3_OR, F3_AND};
        alts = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        // SUB, SLT and SLTU
        sel  = '{1, 3, 4};
        // Positive, negative, all ones and one
        v[0] = $urandom & 32'h7fff_ffff;
        v[1] = $urandom | 32'h8000_0000;
        v[2] = 32'hffff_ffff;
        v[3] = 32'h0000_0001;
        for (int i = 0; i < 4; i++) begin
            preload(8'(4 + i), v[i]);
            load_reg(5'(4 + i), 8'(4 + i));
        end
        out = 8'd64;
        for (int p = 0; p < 2; p++) begin
            ra = p;
            rb = 1 - p;
            for (int k = 0; k < 10; k++) begin
                emit(enc_r(alts[k] ? F7_ALT : F7_BASE, 5'(4 + rb), 5'(4 + ra), f3s[k], 5'd3));
                store_reg(5'd3, out, model_op(f3s[k], alts[k], v[ra], v[rb]));
                out++;
            end
        end
        // Minus one against one, both orders
        for (int p = 0; p < 2; p++) begin
            ra = 2 + p;
            rb = 3 - p;
            for (int k = 0; k < 3; k++) begin
                emit(enc_r(alts[sel[k]] ? F7_ALT : F7_BASE, 5'(4 + rb), 5'(4 + ra),
                           f3s[sel[k]], 5'd3));
                store_reg(5'd3, out, model_op(f3s[sel[k]], alts[sel[k]], v[ra], v[rb]));
                out++;
            end
        end
        run_program();
    endtask

    task automatic shift_test();
        rv32_word_t  v [2];
        rv32_word_t  amt [4];
        logic [2:0]  f3s [3];
        logic        alts [3];
        logic [6:0]  f7;
        rv32_daddr_t out;
        test_name = "shift";
        f3s    = '{F3_SLL, F3_SRL_SRA, F3_SRL_SRA};
        alts   = '{1'b0, 1'b0, 1'b1};
        v[0]   = $urandom | 32'h8000_0000;
        v[1]   = $urandom & 32'h7fff_ffff;
        amt[0] = 32'd0;
        amt[1] = 32'd1;
        amt[2] = 32'd31;
        // Full random word, only its low five bits count
        amt[3] = $urandom;
        preload(8'd8, v[0]);
        preload(8'd9, v[1]);
        load_reg(5'd1, 8'd8);
        load_reg(5'd2, 8'd9);
        for (int j = 0; j < 4; j++) begin
            preload(8'(10 + j), amt[j]);
            load_reg(5'(8 + j), 8'(10 + j));
        end
        out = 8'd96;
        for (int j = 0; j < 4; j++) begin
            for (int k = 0; k < 3; k++) begin
                f7 = alts[k] ? F7_ALT : F7_BASE;
                emit(enc_i({f7, amt[j][4:0]}, 5'd1, f3s[k], 5'd3, OP_IMM));
                store_reg(5'd3, out, model_op(f3s[k], alts[k], v[0], {27'b0, amt[j][4:0]}));
                out++;
                emit(enc_r(f7, 5'(8 + j), 5'd1, f3s[k], 5'd3));
                store_reg(5'd3, out, model_op(f3s[k], alts[k], v[0], amt[j]));
                out++;
            end
        end
        // SRA of a positive value fills with zeros
        emit(enc_r(F7_ALT, 5'd11, 5'd2, F3_SRL_SRA, 5'd3));
        store_reg(5'd3, out, model_op(F3_SRL_SRA, 1'b1, v[1], amt[3]));
        run_program();
    endtask

    task automatic x0_nop_test();
        rv32_word_t  sent [3];
        logic [10:0] k;
        test_name = "x0_nop";
        k = 11'($urandom);
        // Sentinels that no supported instruction touches
        for (int i = 0; i < 3; i++) begin
            sent[i] = $urandom | 32'h1;
            preload(8'(128 + i), sent[i]);
            expect_word(8'(128 + i), sent[i]);
        end
        preload(8'd131, 32'hffff_ffff);
        preload(8'd132, 32'hffff_ffff);
        // ALU, LUI and LW results aimed at x0 all vanish
        emit(enc_i(12'($urandom), 5'd0, F3_ADD_SUB, 5'd0, OP_IMM));
        emit(enc_u(20'($urandom), 5'd0));
        store_reg(5'd0, 8'd131, '0);
        load_reg(5'd0, 8'd128);
        store_reg(5'd0, 8'd132, '0);
        // x3 must keep this value through every NOP below
        emit(enc_i({1'b0, k}, 5'd0, F3_ADD_SUB, 5'd3, OP_IMM));
        emit(32'h0000_0000);
        emit(32'hffff_ffff);
        emit(enc_s(12'(129 * 4), 5'd3, 5'd0, 3'b000));
        emit(enc_s(12'(130 * 4), 5'd3, 5'd0, 3'b001));
        // LB, MUL, AND with funct7 alt, SLLI with funct7 alt
        emit(enc_i(12'(128 * 4), 5'd0, 3'b000, 5'd3, LOAD));
        emit(enc_r(7'b0000001, 5'd0, 5'd0, F3_ADD_SUB, 5'd3));
        emit(enc_r(F7_ALT, 5'd0, 5'd0, F3_AND, 5'd3));
        emit(enc_i({F7_ALT, 5'd1}, 5'd0, F3_SLL, 5'd3, OP_IMM));
        // JAL x3, AUIPC x3, BEQ x0 x0
        emit(32'h0000_01ef);
        emit(32'h1234_5197);
        emit(32'h0000_0063);
        store_reg(5'd3, 8'd133, {21'b0, k});
        run_program();
    endtask

    // ============================================================
    // Main sequence and timeout
    // ============================================================
    initial begin
        void'($urandom(32'h5dd76f1a));
        rst          = 1'b1;
        program_mode = 1'b1;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        dmem_we      = 1'b0;
        dmem_addr    = '0;
        dmem_wdata   = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        host_rw_test();
        imm_alu_test();
        reg_alu_test();
        shift_test();
        x0_nop_test();
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, i_dut.i_chk.fails);
        if (errors == 0 && i_dut.i_chk.fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, tests did not finish", cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
hw/rv32_isa_pkg.sv
hw/rv32_mem_pkg.sv
hw/rv32_word_ram.sv
hw/rv32_regfile.sv
hw/rv32_decoder.sv
hw/rv32_alu.sv
hw/rv32_core.sv
tests/rv32_core_chk.sv
tests/rv32_core_tb.sv
